/* include/uart_settings.svh */
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// clk cycles per oversampling tick
// The line rate is clk / (UART_CLK_DIV * UART_OVERSAMPLE)
`define UART_CLK_DIV 2

// Ticks per bit
// The receiver samples at the middle tick, so this stays at 8
`define UART_OVERSAMPLE 8

// FIFO depths in bytes, powers of two
`define UART_RX_DEPTH 4
`define UART_TX_DEPTH 4

`endif

/* hw/uart_pkg.sv */
package uart_pkg;

    // One data byte on the link
    typedef logic [7:0] uart_byte_t;

    // Transmitter frame phase
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_t;

endpackage

/* hw/uart_baud_gen.sv */
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_baud_gen (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int CW = (`UART_CLK_DIV > 1) ? $clog2(`UART_CLK_DIV) : 1;
    localparam logic [CW-1:0] CNT_LAST = CW'(`UART_CLK_DIV - 1);

    logic [CW-1:0] cnt;

    // Tick is registered so both directions see a clean one-cycle pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == CNT_LAST) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

/* hw/uart_rx.sv */
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_rx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       uart_rxd,
    output uart_byte_t rx_data,
    output logic       rx_valid,
    output logic       framing_error,
    output logic       break_det
);

    localparam int TW = $clog2(`UART_OVERSAMPLE);
    localparam logic [TW-1:0] SAMPLE_TICK = TW'(`UART_OVERSAMPLE / 2);
    localparam logic [3:0] STOP_BIT = 4'd9;

    logic [3:0]    rxd_sync;
    logic          rx_in;
    logic          start_edge;
    logic          started;
    logic [TW-1:0] tick_cnt;
    logic          sample;
    logic          stop_sample;
    logic [3:0]    bit_cnt;
    uart_byte_t    shift;

    // Line synchronizer, two stages before the line is used
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_sync <= 4'hf;
        end else begin
            rxd_sync <= {rxd_sync[2:0], uart_rxd};
        end
    end

    assign rx_in      = rxd_sync[2];
    assign start_edge = (rxd_sync[3:2] == 2'b10);

    // Tick count within the current bit, restarted at each start edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
        end else if (!started) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign sample      = started && tick && (tick_cnt == SAMPLE_TICK);
    assign stop_sample = sample && (bit_cnt == STOP_BIT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            started       <= 1'b0;
            rx_valid      <= 1'b0;
            bit_cnt       <= '0;
            framing_error <= 1'b0;
            break_det     <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!started) begin
                bit_cnt       <= '0;
                framing_error <= 1'b0;
                break_det     <= 1'b0;
                if (start_edge) begin
                    started <= 1'b1;
                end
            end else if (stop_sample) begin
                if (rx_in) begin
                    started  <= 1'b0;
                    // A frame that ended badly is never delivered
                    rx_valid <= !(framing_error || break_det);
                end else if (shift == 8'h00) begin
                    break_det <= 1'b1;
                end else begin
                    framing_error <= 1'b1;
                end
            end else if (sample) begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    // Start bit shifts in first and drops out after the eighth data bit
    always_ff @(posedge clk) begin
        if (sample && !stop_sample) begin
            shift <= {rx_in, shift[7:1]};
        end
        if (stop_sample && rx_in) begin
            rx_data <= shift;
        end
    end

    a_no_valid_on_error: assert property (
        @(posedge clk) disable iff (rst)
        rx_valid |-> !(framing_error || break_det)
    );

endmodule

/* hw/uart_fifo.sv */
`timescale 1ns/1ps

module uart_fifo
    import uart_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  logic       pop,
    input  uart_byte_t wdata,
    output uart_byte_t rdata,
    output logic       empty,
    output logic       full,
    output logic       overrun
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    uart_byte_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          push_ok;
    logic          pop_ok;

    assign empty   = (count == '0);
    assign full    = (count == CW'(DEPTH));
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    // Head is always visible
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky until reset
            if (push && full) begin
                overrun <= 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !empty
    );

endmodule

/* hw/uart_tx.sv */
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       tick,
    input  logic       fifo_empty,
    input  uart_byte_t fifo_data,
    output logic       fifo_pop,
    output logic       uart_txd
);

    localparam int TW = $clog2(`UART_OVERSAMPLE);
    localparam logic [TW-1:0] TICK_LAST = TW'(`UART_OVERSAMPLE - 1);

    uart_tx_state_t state;
    logic [TW-1:0]  tick_cnt;
    logic [2:0]     bit_cnt;
    logic           bit_end;
    uart_byte_t     shift;

    assign bit_end = tick && (tick_cnt == TICK_LAST);

    // Pop on a tick so the start bit is a whole number of ticks
    // End of a stop bit can chain straight into the next frame
    assign fifo_pop = !fifo_empty && tick &&
                      ((state == TX_IDLE) || (state == TX_STOP && bit_end));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            uart_txd <= 1'b1;
        end else begin
            if (state != TX_IDLE && tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            if (fifo_pop) begin
                state    <= TX_START;
                tick_cnt <= '0;
                uart_txd <= 1'b0;
            end else if (bit_end) begin
                case (state)
                    TX_START: begin
                        state    <= TX_DATA;
                        bit_cnt  <= '0;
                        uart_txd <= shift[0];
                    end
                    TX_DATA: begin
                        if (bit_cnt == 3'd7) begin
                            state    <= TX_STOP;
                            uart_txd <= 1'b1;
                        end else begin
                            bit_cnt  <= bit_cnt + 3'd1;
                            uart_txd <= shift[0];
                        end
                    end
                    TX_STOP: state <= TX_IDLE;
                    default: state <= TX_IDLE;
                endcase
            end
        end
    end

    // LSB first, next bit always sits in shift[0]
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            shift <= fifo_data;
        end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (rst)
        (state == TX_IDLE) |-> uart_txd
    );

endmodule

/* hw/uart_link_top.sv */
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_link_top
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       uart_rxd,
    output logic       uart_txd,
    input  logic       rd_en,
    output uart_byte_t rd_data,
    output logic       rd_empty,
    input  logic       wr_en,
    input  uart_byte_t wr_data,
    output logic       wr_full,
    output logic       framing_error,
    output logic       break_det,
    output logic       overrun
);

    logic       tick;
    uart_byte_t rx_data;
    logic       rx_valid;
    uart_byte_t tx_data;
    logic       tx_empty;
    logic       tx_pop;

    uart_baud_gen u_baud_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    uart_rx u_rx (
        .clk           (clk),
        .rst           (rst),
        .tick          (tick),
        .uart_rxd      (uart_rxd),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .framing_error (framing_error),
        .break_det     (break_det)
    );

    // Host reads on an empty FIFO are dropped here
    uart_fifo #(
        .DEPTH (`UART_RX_DEPTH)
    ) u_rx_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (rx_valid),
        .pop     (rd_en && !rd_empty),
        .wdata   (rx_data),
        .rdata   (rd_data),
        .empty   (rd_empty),
        .full    (),
        .overrun (overrun)
    );

    uart_fifo #(
        .DEPTH (`UART_TX_DEPTH)
    ) u_tx_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (wr_en),
        .pop     (tx_pop),
        .wdata   (wr_data),
        .rdata   (tx_data),
        .empty   (tx_empty),
        .full    (wr_full),
        .overrun ()
    );

    uart_tx u_tx (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .fifo_empty (tx_empty),
        .fifo_data  (tx_data),
        .fifo_pop   (tx_pop),
        .uart_txd   (uart_txd)
    );

endmodule

/* tests/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 100.0,
    parameter int  RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Release away from the active edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* tests/tb_uart_link.sv */
`timescale 1ns/1ps
`include "uart_settings.svh"

module tb_uart_link
    import uart_pkg::*;
();

    localparam int BIT_CLKS  = `UART_CLK_DIV * `UART_OVERSAMPLE;
    localparam int FRAME     = 10 * BIT_CLKS;
    localparam int ST_EMPTY  = 0;
    localparam int ST_FE     = 1;
    localparam int ST_BRK    = 2;
    localparam int ST_OVR    = 3;

    logic       clk;
    logic       rst;
    logic       uart_rxd;
    logic       uart_txd;
    logic       rd_en;
    uart_byte_t rd_data;
    logic       rd_empty;
    logic       wr_en;
    uart_byte_t wr_data;
    logic       wr_full;
    logic       framing_error;
    logic       break_det;
    logic       overrun;

    int         mismatches;
    int         timeouts;
    uart_byte_t tx_expect[$];

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    uart_link_top uart_link_top_i (
        .clk           (clk),
        .rst           (rst),
        .uart_rxd      (uart_rxd),
        .uart_txd      (uart_txd),
        .rd_en         (rd_en),
        .rd_data       (rd_data),
        .rd_empty      (rd_empty),
        .wr_en         (wr_en),
        .wr_data       (wr_data),
        .wr_full       (wr_full),
        .framing_error (framing_error),
        .break_det     (break_det),
        .overrun       (overrun)
    );

    task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp) begin
            $display("Fail %0t ns %s: got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %0t ns %s: got %b expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    function automatic logic status_of(input int sel);
        case (sel)
            ST_EMPTY: return rd_empty;
            ST_FE:    return framing_error;
            ST_BRK:   return break_det;
            default:  return overrun;
        endcase
    endfunction

    task automatic wait_status(input string name, input int sel, input logic level,
                               input int limit);
        int n;
        n = 0;
        while (status_of(sel) !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (status_of(sel) !== level) begin
            $display("Timeout at %0t ns: %s never went to %b", $time, name, level);
            timeouts++;
        end
    endtask

    // Serial line model, all changes on the falling edge
    task automatic drive_bit(input logic v);
        uart_rxd = v;
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    task automatic send_frame(input uart_byte_t b, input logic stop_low);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(!stop_low);
    endtask

    task automatic read_and_check(input uart_byte_t exp);
        wait_status("rd_empty", ST_EMPTY, 1'b0, 2 * FRAME);
        check_byte("rd_data", rd_data, exp);
        rd_en = 1'b1;
        @(negedge clk);
        rd_en = 1'b0;
    endtask

    task automatic write_tx_bytes(input int n);
        for (int i = 0; i < n; i++) begin
            wr_en   = 1'b1;
            wr_data = uart_byte_t'($urandom);
            tx_expect.push_back(wr_data);
            @(negedge clk);
        end
        wr_en = 1'b0;
    endtask

    // Start edge, then mid-bit samples
    task automatic receive_tx_byte(output uart_byte_t b);
        int n;
        n = 0;
        b = '0;
        while (uart_txd !== 1'b0 && n < 2 * FRAME) begin
            @(negedge clk);
            n++;
        end
        if (uart_txd !== 1'b0) begin
            $display("Timeout at %0t ns: no start bit seen on uart_txd", $time);
            timeouts++;
            return;
        end
        repeat (BIT_CLKS / 2) @(negedge clk);
        check_bit("uart_txd start bit", uart_txd, 1'b0);
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            b[i] = uart_txd;
        end
        repeat (BIT_CLKS) @(negedge clk);
        check_bit("uart_txd stop bit", uart_txd, 1'b1);
    endtask

    task automatic collect_tx_bytes(input int n);
        uart_byte_t got;
        uart_byte_t exp;
        for (int i = 0; i < n; i++) begin
            receive_tx_byte(got);
            exp = tx_expect.pop_front();
            check_byte("uart_txd byte", got, exp);
        end
    endtask

    task automatic check_line_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bit("uart_txd idle", uart_txd, 1'b1);
        end
    endtask

    task automatic test_receive(input int n);
        uart_byte_t b;
        for (int i = 0; i < n; i++) begin
            b = uart_byte_t'($urandom);
            send_frame(b, 1'b0);
            read_and_check(b);
            check_bit("rd_empty", rd_empty, 1'b1);
            check_bit("framing_error", framing_error, 1'b0);
            check_bit("break_det", break_det, 1'b0);
        end
    endtask

    task automatic test_transmit(input int runs, input int n);
        repeat (runs) begin
            fork
                write_tx_bytes(n);
                collect_tx_bytes(1);
            join
            collect_tx_bytes(n - 1);
            check_line_idle(2 * BIT_CLKS);
        end
    endtask

    task automatic test_framing_error();
        uart_byte_t b;
        b = uart_byte_t'($urandom % 255) + 8'd1;
        send_frame(b, 1'b1);
        wait_status("framing_error", ST_FE, 1'b1, FRAME);
        check_bit("break_det", break_det, 1'b0);
        check_bit("rd_empty", rd_empty, 1'b1);
        uart_rxd = 1'b1;
        wait_status("framing_error", ST_FE, 1'b0, 4 * BIT_CLKS);
        check_bit("rd_empty", rd_empty, 1'b1);
    endtask

    task automatic test_break();
        send_frame(8'h00, 1'b1);
        wait_status("break_det", ST_BRK, 1'b1, FRAME);
        check_bit("framing_error", framing_error, 1'b0);
        check_bit("rd_empty", rd_empty, 1'b1);
        uart_rxd = 1'b1;
        wait_status("break_det", ST_BRK, 1'b0, 4 * BIT_CLKS);
        check_bit("rd_empty", rd_empty, 1'b1);
    endtask

    task automatic test_rx_overrun();
        uart_byte_t sent[$];
        uart_byte_t b;
        for (int i = 0; i < `UART_RX_DEPTH + 1; i++) begin
            b = uart_byte_t'($urandom);
            sent.push_back(b);
            send_frame(b, 1'b0);
        end
        wait_status("overrun", ST_OVR, 1'b1, FRAME);
        for (int i = 0; i < `UART_RX_DEPTH; i++) begin
            read_and_check(sent[i]);
        end
        check_bit("rd_empty", rd_empty, 1'b1);
    endtask

    task automatic fill_tx_fifo(output int count);
        count = 0;
        while (!wr_full && count < `UART_TX_DEPTH + 2) begin
            wr_en   = 1'b1;
            wr_data = uart_byte_t'($urandom);
            tx_expect.push_back(wr_data);
            count++;
            @(negedge clk);
        end
        wr_en = 1'b0;
        check_bit("wr_full", wr_full, 1'b1);
    endtask

    task automatic test_tx_backpressure();
        int accepted;
        fork
            fill_tx_fifo(accepted);
            collect_tx_bytes(1);
        join
        // One more fits if the transmitter already took the first byte
        if (accepted != `UART_TX_DEPTH && accepted != `UART_TX_DEPTH + 1) begin
            $display("Error at %0t ns: wr_full rose after %0d writes", $time, accepted);
            mismatches++;
        end
        collect_tx_bytes(accepted - 1);
        check_line_idle(2 * BIT_CLKS);
    endtask

    initial begin : main
        int seed;
        int n;
        uart_rxd   = 1'b1;
        rd_en      = 1'b0;
        wr_en      = 1'b0;
        wr_data    = '0;
        mismatches = 0;
        timeouts   = 0;
        seed       = $urandom(32'hdb7b);
        n          = 0;
        while (rst !== 1'b0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("Timeout at %0t ns: reset never released", $time);
            timeouts++;
        end
        repeat (4) @(negedge clk);
        check_bit("uart_txd", uart_txd, 1'b1);
        check_bit("rd_empty", rd_empty, 1'b1);
        check_bit("overrun", overrun, 1'b0);

        test_receive(6);
        test_transmit(2, 3);
        test_framing_error();
        test_break();
        test_rx_overrun();
        test_tx_backpressure();

        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_rx.sv
hw/uart_fifo.sv
hw/uart_tx.sv
hw/uart_link_top.sv
tests/tb_clk_gen.sv
tests/tb_uart_link.sv

/* Bender.yml */
package:
  name: uart_link

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/uart_pkg.sv
      - hw/uart_baud_gen.sv
      - hw/uart_rx.sv
      - hw/uart_fifo.sv
      - hw/uart_tx.sv
      - hw/uart_link_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_uart_link.sv
